//--- design/spd_pkg.sv
package spd_pkg;

    typedef logic [6:0] dev_addr_t;     // i2c device address
    typedef logic [7:0] spd_index_t;
    typedef logic [7:0] spd_byte_t;
    typedef logic [7:0] char_t;         // ascii
    typedef logic [4:0] line_len_t;

    localparam int         LINE_CHARS       = 24;     // longest line plus lf, padded
    localparam dev_addr_t  FIRST_PROBE_ADDR = 7'd1;   // 0 is the general call
    localparam dev_addr_t  LAST_PROBE_ADDR  = 7'd127;
    localparam spd_index_t LAST_SPD_BYTE    = 8'd18;
    localparam spd_byte_t  DDR3_TYPE_CODE   = 8'h0B;
    localparam char_t      LF_CHAR          = 8'h0A;

    // spd bytes that produce a report line
    localparam spd_index_t SPD_IDX_REVISION    = 8'd1;
    localparam spd_index_t SPD_IDX_DRAM_TYPE   = 8'd2;
    localparam spd_index_t SPD_IDX_MODULE_TYPE = 8'd3;
    localparam spd_index_t SPD_IDX_BUS_WIDTH   = 8'd8;
    localparam spd_index_t SPD_IDX_TRCD        = 8'd18;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic [14:0] adr;   // {device address, spd index}
    } wb_req_t;

    typedef struct packed {
        logic      ack;
        logic      err;     // stands for an i2c nack
        spd_byte_t dat;
    } wb_rsp_t;

    // address items carry the probe address zero extended in data
    typedef struct packed {
        logic       is_addr;
        spd_index_t index;
        spd_byte_t  data;
    } spd_item_t;

    typedef struct packed {
        line_len_t                  len;
        char_t [0:LINE_CHARS-1]     chars;  // chars[0] goes out first
    } text_line_t;

    typedef enum logic [2:0] {
        PROBE_REQ,
        PROBE_WAIT,
        REPORT_ADDR,
        READ_REQ,
        READ_WAIT,
        REPORT_BYTE,
        FINISHED,
        FAILED
    } seq_state_e;

    typedef enum logic {
        SEND_IDLE,
        SEND_CHAR
    } send_state_e;

    function automatic char_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + char_t'(nib);    // '0'..'9'
        end
        return 8'h37 + char_t'(nib);        // 'A'..'F'
    endfunction

endpackage

//--- design/spd_sequencer.sv
`timescale 1ns/1ps

module spd_sequencer import spd_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    output wb_req_t   o_wb,
    input  wb_rsp_t   i_wb,
    output spd_item_t o_item,
    output logic      o_item_valid,
    input  logic      i_item_done,
    output logic      o_addr_found,
    output logic      o_read_done,
    output logic      o_spd_error
);

    seq_state_e state;
    dev_addr_t  dev_addr;
    spd_index_t index;      // stays 0 while probing
    logic       wb_cyc;

    // dev_addr and index only move while no bus cycle is open
    assign o_wb = '{cyc: wb_cyc, stb: wb_cyc, adr: {dev_addr, index}};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= PROBE_REQ;
            dev_addr     <= FIRST_PROBE_ADDR;
            index        <= '0;
            wb_cyc       <= 1'b0;
            o_item_valid <= 1'b0;
            o_addr_found <= 1'b0;
            o_read_done  <= 1'b0;
            o_spd_error  <= 1'b0;
        end else begin
            case (state)
                PROBE_REQ: begin
                    wb_cyc <= 1'b1;
                    state  <= PROBE_WAIT;
                end
                PROBE_WAIT: begin
                    if (i_wb.ack) begin         // device found
                        wb_cyc       <= 1'b0;
                        o_item_valid <= 1'b1;
                        state        <= REPORT_ADDR;
                    end else if (i_wb.err) begin
                        wb_cyc <= 1'b0;
                        if (dev_addr == LAST_PROBE_ADDR) begin
                            state <= FAILED;    // nobody answered
                        end else begin
                            dev_addr <= dev_addr + 7'd1;
                            state    <= PROBE_REQ;
                        end
                    end
                end
                REPORT_ADDR: begin
                    if (i_item_done) begin
                        o_item_valid <= 1'b0;
                        o_addr_found <= 1'b1;
                        state        <= READ_REQ;
                    end
                end
                READ_REQ: begin
                    wb_cyc <= 1'b1;
                    state  <= READ_WAIT;
                end
                READ_WAIT: begin
                    if (i_wb.ack) begin
                        wb_cyc       <= 1'b0;
                        o_item_valid <= 1'b1;
                        state        <= REPORT_BYTE;
                    end else if (i_wb.err) begin
                        wb_cyc <= 1'b0;
                        state  <= FAILED;       // device went away mid read
                    end
                end
                REPORT_BYTE: begin
                    if (i_item_done) begin
                        o_item_valid <= 1'b0;
                        if (index == LAST_SPD_BYTE) begin
                            state <= FINISHED;
                        end else begin
                            index <= index + 8'd1;
                            state <= READ_REQ;
                        end
                    end
                end
                FINISHED: o_read_done <= 1'b1;
                FAILED:   o_spd_error <= 1'b1;
            endcase
        end
    end

    // item payload, loaded on the ack that ends a cycle
    always_ff @(posedge i_clk) begin
        if (state == PROBE_WAIT && i_wb.ack) begin
            o_item <= '{is_addr: 1'b1, index: '0, data: {1'b0, dev_addr}};
        end else if (state == READ_WAIT && i_wb.ack) begin
            o_item <= '{is_addr: 1'b0, index: index, data: i_wb.dat};
        end
    end

endmodule

//--- design/spd_line_formatter.sv
`timescale 1ns/1ps

module spd_line_formatter import spd_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  spd_item_t  i_item,
    input  logic       i_item_valid,
    output logic       o_item_done,
    output text_line_t o_line,
    output logic       o_line_valid,
    input  logic       i_line_sent
);

    text_line_t fmt_line;
    logic       fmt_skip;
    logic       accept;
    spd_byte_t  value;
    char_t      lane_char;

    // text comes in right aligned, first char is moved to chars[0]
    function automatic text_line_t make_line(input logic [8*LINE_CHARS-1:0] text,
                                             input line_len_t len);
        text_line_t l;
        l.len   = len;
        l.chars = text << (8 * (LINE_CHARS - int'(len)));
        return l;
    endfunction

    assign value     = i_item.data;
    assign lane_char = 8'h30 + (8'd1 << value[1:0]);  // 1, 2, 4 or 8
    // not while a line is out or the done pulse is still up
    assign accept    = i_item_valid && !o_line_valid && !o_item_done;

    always_comb begin
        fmt_line = '0;
        fmt_skip = 1'b0;
        if (i_item.is_addr) begin
            fmt_line = make_line({"I2C Address: 0x", hex_char({1'b0, value[6:4]}),
                                  hex_char(value[3:0]), LF_CHAR}, 5'd18);
        end else begin
            case (i_item.index)
                8'h00: begin    // first byte read opens the report
                    fmt_line = make_line({"START SPD READ", LF_CHAR}, 5'd15);
                end
                SPD_IDX_REVISION: begin
                    fmt_line = make_line({"SPD Revision: ", hex_char(value[7:4]), ".",
                                          hex_char(value[3:0]), LF_CHAR}, 5'd18);
                end
                SPD_IDX_DRAM_TYPE: begin
                    if (value == DDR3_TYPE_CODE) begin
                        fmt_line = make_line({"DRAM Type: DDR3 SDRAM", LF_CHAR}, 5'd22);
                    end else begin
                        fmt_line = make_line({"DRAM Type: NOT DDR3!", LF_CHAR}, 5'd21);
                    end
                end
                SPD_IDX_MODULE_TYPE: begin
                    case (value)
                        8'h00: fmt_line = make_line({"Module Type: Undefined!", LF_CHAR}, 5'd24);
                        8'h01: fmt_line = make_line({"Module Type: RDIMM", LF_CHAR}, 5'd19);
                        8'h02: fmt_line = make_line({"Module Type: UDIMM", LF_CHAR}, 5'd19);
                        8'h03: fmt_line = make_line({"Module Type: SO-DIMM", LF_CHAR}, 5'd21);
                        default: fmt_skip = 1'b1;
                    endcase
                end
                SPD_IDX_BUS_WIDTH: begin
                    if (value[2]) begin
                        fmt_skip = 1'b1;    // codes 4..7 are reserved
                    end else begin
                        fmt_line = make_line({"BYTE_LANES: ", lane_char, LF_CHAR}, 5'd14);
                    end
                end
                SPD_IDX_TRCD: begin
                    fmt_line = make_line({"TRCD: mtb * 0x", hex_char(value[7:4]),
                                          hex_char(value[3:0]), LF_CHAR}, 5'd17);
                end
                default: fmt_skip = 1'b1;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_line_valid <= 1'b0;
            o_item_done  <= 1'b0;
        end else begin
            o_item_done <= 1'b0;    // single cycle pulse
            if (accept) begin
                if (fmt_skip) begin
                    o_item_done <= 1'b1;
                end else begin
                    o_line_valid <= 1'b1;
                end
            end else if (o_line_valid && i_line_sent) begin
                o_line_valid <= 1'b0;
                o_item_done  <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_line <= fmt_line;
        end
    end

endmodule

//--- design/spd_text_sender.sv
`timescale 1ns/1ps

module spd_text_sender import spd_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  text_line_t i_line,
    input  logic       i_line_valid,
    output logic       o_line_sent,
    output logic       o_char_valid,
    output char_t      o_char,
    input  logic       i_char_ready
);

    send_state_e state;
    text_line_t  line_q;
    line_len_t   char_idx;
    line_len_t   last_idx;

    assign last_idx     = line_q.len - 5'd1;
    assign o_char_valid = (state == SEND_CHAR);
    assign o_char       = line_q.chars[char_idx];   // held while ready is low

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= SEND_IDLE;
            char_idx    <= '0;
            o_line_sent <= 1'b0;
        end else begin
            o_line_sent <= 1'b0;
            case (state)
                SEND_IDLE: begin
                    // line_valid is still up during the sent pulse
                    if (i_line_valid && !o_line_sent) begin
                        char_idx <= '0;
                        state    <= SEND_CHAR;
                    end
                end
                SEND_CHAR: begin
                    if (i_char_ready) begin
                        if (char_idx == last_idx) begin
                            o_line_sent <= 1'b1;
                            state       <= SEND_IDLE;
                        end else begin
                            char_idx <= char_idx + 5'd1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == SEND_IDLE && i_line_valid) begin
            line_q <= i_line;
        end
    end

endmodule

//--- design/spd_reader.sv
`timescale 1ns/1ps

module spd_reader import spd_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst_n,
    output wb_req_t o_wb,
    input  wb_rsp_t i_wb,
    output logic    o_char_valid,
    output char_t   o_char,
    input  logic    i_char_ready,
    output logic    o_addr_found,
    output logic    o_read_done,
    output logic    o_spd_error
);

    spd_item_t  item;
    logic       item_valid;
    logic       item_done;
    text_line_t line;
    logic       line_valid;
    logic       line_sent;

    spd_sequencer u_sequencer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .o_wb         (o_wb),
        .i_wb         (i_wb),
        .o_item       (item),
        .o_item_valid (item_valid),
        .i_item_done  (item_done),
        .o_addr_found (o_addr_found),
        .o_read_done  (o_read_done),
        .o_spd_error  (o_spd_error)
    );

    spd_line_formatter u_formatter (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_item       (item),
        .i_item_valid (item_valid),
        .o_item_done  (item_done),
        .o_line       (line),
        .o_line_valid (line_valid),
        .i_line_sent  (line_sent)
    );

    spd_text_sender u_sender (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_line       (line),
        .i_line_valid (line_valid),
        .o_line_sent  (line_sent),
        .o_char_valid (o_char_valid),
        .o_char       (o_char),
        .i_char_ready (i_char_ready)
    );

endmodule

//--- tb/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    input  logic i_reset_req,   // sampled on the rising edge
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #50 o_clk = ~o_clk;     // 100 ns period
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (8) @(posedge o_clk);
        o_rst_n <= 1'b1;
        forever begin
            @(posedge o_clk);
            if (i_reset_req) begin
                o_rst_n <= 1'b0;
                repeat (8) @(posedge o_clk);
                o_rst_n <= 1'b1;
            end
        end
    end

endmodule

//--- tb/tb_spd_model.sv
`timescale 1ns/1ps

module tb_spd_model import spd_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  wb_req_t     i_wb,
    output wb_rsp_t     o_wb,
    input  logic [31:0] i_rand,         // wait cycle source
    input  dev_addr_t   i_dev_addr,
    input  logic        i_present,
    input  logic        i_err_en,
    input  spd_index_t  i_err_idx,
    input  spd_byte_t   i_image [0:18]
);

    logic       busy;
    logic [1:0] wait_cnt;
    logic       ack;
    logic       err;
    spd_byte_t  dat;
    dev_addr_t  req_dev;
    spd_index_t req_idx;
    logic       nack;

    assign req_dev = i_wb.adr[14:8];
    assign req_idx = i_wb.adr[7:0];
    assign o_wb    = '{ack: ack, err: err, dat: dat};
    // wrong address, missing device, forced error or index past the image
    assign nack    = !i_present || (req_dev != i_dev_addr) ||
                     (i_err_en && (req_idx == i_err_idx)) || (req_idx > 8'd18);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy     <= 1'b0;
            wait_cnt <= 2'd0;
            ack      <= 1'b0;
            err      <= 1'b0;
            dat      <= '0;
        end else begin
            ack <= 1'b0;
            err <= 1'b0;
            if (!busy) begin
                if (i_wb.cyc && i_wb.stb && !ack && !err) begin
                    busy     <= 1'b1;
                    wait_cnt <= 2'(i_rand[7:0] % 8'd3);    // 1 to 3 wait cycles in total
                end
            end else if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                busy <= 1'b0;
                if (nack) begin
                    err <= 1'b1;
                end else begin
                    ack <= 1'b1;
                    dat <= i_image[req_idx[4:0]];
                end
            end
        end
    end

endmodule

//--- tb/tb_checker.sv
`timescale 1ns/1ps

module tb_checker import spd_pkg::*; (
    input logic      i_clk,
    input logic      i_rst_n,
    input logic      i_char_valid,
    input char_t     i_char,
    input logic      i_char_ready,
    input logic      i_addr_found,
    input logic      i_read_done,
    input logic      i_spd_error,
    input spd_byte_t i_image [0:18]
);

    char_t       exp_q[$];
    int unsigned char_pos;
    int unsigned value_errors;
    int unsigned other_errors;
    string       test_name;
    logic        active;

    initial begin
        char_pos     = 0;
        value_errors = 0;
        other_errors = 0;
        active       = 1'b0;
    end

    function automatic void push_char(input char_t c);
        exp_q.push_back(c);
    endfunction

    function automatic void push_text(input string s);
        for (int i = 0; i < s.len(); i++) begin
            exp_q.push_back(char_t'(s[i]));
        end
    endfunction

    function automatic void push_hex(input spd_byte_t v);
        push_char(hex_char(v[7:4]));
        push_char(hex_char(v[3:0]));
    endfunction

    // expected report text for one run
    function automatic void build_expected(input dev_addr_t dev, input logic present,
                                           input logic err_en, input spd_index_t err_idx);
        spd_byte_t v;
        exp_q.delete();
        if (!present) begin
            return;
        end
        push_text("I2C Address: 0x");
        push_hex({1'b0, dev});
        push_char(LF_CHAR);
        for (int i = 0; i <= 18; i++) begin
            if (err_en && (i == int'(err_idx))) begin
                break;      // the report stops at the failed read
            end
            v = i_image[i];
            case (i)
                0: push_text("START SPD READ");
                1: begin
                    push_text("SPD Revision: ");
                    push_char(hex_char(v[7:4]));
                    push_text(".");
                    push_char(hex_char(v[3:0]));
                end
                2: begin
                    if (v == 8'h0B) begin
                        push_text("DRAM Type: DDR3 SDRAM");
                    end else begin
                        push_text("DRAM Type: NOT DDR3!");
                    end
                end
                3: begin
                    case (v)
                        8'd0: push_text("Module Type: Undefined!");
                        8'd1: push_text("Module Type: RDIMM");
                        8'd2: push_text("Module Type: UDIMM");
                        8'd3: push_text("Module Type: SO-DIMM");
                        default: ;
                    endcase
                end
                8: begin
                    case (v[2:0])
                        3'd0: push_text("BYTE_LANES: 1");
                        3'd1: push_text("BYTE_LANES: 2");
                        3'd2: push_text("BYTE_LANES: 4");
                        3'd3: push_text("BYTE_LANES: 8");
                        default: ;
                    endcase
                end
                18: begin
                    push_text("TRCD: mtb * 0x");
                    push_hex(v);
                end
                default: ;
            endcase
            if ((i == 0) || (i == 1) || (i == 2) || (i == 18) ||
                ((i == 3) && (v <= 8'd3)) || ((i == 8) && (v[2:0] <= 3'd3))) begin
                push_char(LF_CHAR);
            end
        end
    endfunction

    task automatic begin_test(input string name, input dev_addr_t dev, input logic present,
                              input logic err_en, input spd_index_t err_idx);
        test_name = name;
        build_expected(dev, present, err_en, err_idx);
        char_pos = 0;
        active   = 1'b1;
    endtask

    task automatic check_flag(input string flag, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("CHECK FAILED: %s: %s expected %0b actual %0b", test_name, flag, exp, act);
        end
    endtask

    task automatic end_test(input logic exp_found, input logic exp_done, input logic exp_err);
        active = 1'b0;
        if (char_pos != exp_q.size()) begin
            other_errors++;
            $display("ERROR: %s: report ended after %0d of %0d characters",
                     test_name, char_pos, exp_q.size());
        end
        check_flag("o_addr_found", exp_found, i_addr_found);
        check_flag("o_read_done", exp_done, i_read_done);
        check_flag("o_spd_error", exp_err, i_spd_error);
    endtask

    task automatic count_failure();
        other_errors++;
    endtask

    function automatic int unsigned error_total();
        return value_errors + other_errors;
    endfunction

    task automatic report_counts(input int unsigned assert_errors);
        $display("error counts: value %0d, other %0d, assertion %0d",
                 value_errors, other_errors, assert_errors);
    endtask

    // every transfer is compared in order
    always @(posedge i_clk) begin
        if (active && i_rst_n && i_char_valid && i_char_ready) begin
            if (char_pos >= exp_q.size()) begin
                other_errors++;
                $display("ERROR: %s: character 0x%02h sent after the end of the report",
                         test_name, i_char);
            end else if (i_char !== exp_q[char_pos]) begin
                value_errors++;
                $display("CHECK FAILED: %s: char %0d expected 0x%02h actual 0x%02h",
                         test_name, char_pos, exp_q[char_pos], i_char);
            end
            char_pos++;
        end
    end

endmodule

//--- tb/spd_reader_asserts.sv
`timescale 1ns/1ps

module spd_reader_asserts import spd_pkg::*; (
    input logic    i_clk,
    input logic    i_rst_n,
    input wb_req_t i_wb_req,
    input wb_rsp_t i_wb_rsp,
    input logic    i_char_valid,
    input char_t   i_char,
    input logic    i_char_ready,
    input logic    i_read_done,
    input logic    i_spd_error
);

    int unsigned fail_count = 0;

    stb_needs_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_req.stb |-> i_wb_req.cyc)
        else begin fail_count++; $error("stb without cyc"); end

    // cyc, stb and adr all hold until the slave answers
    cyc_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_req.cyc && !i_wb_rsp.ack && !i_wb_rsp.err |=>
            i_wb_req.cyc && i_wb_req.stb && $stable(i_wb_req.adr))
        else begin fail_count++; $error("cyc, stb or adr changed before ack or err"); end

    char_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_char_valid && !i_char_ready |=> i_char_valid && $stable(i_char))
        else begin fail_count++; $error("character changed while stalled"); end

    done_xor_error: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_read_done && i_spd_error))
        else begin fail_count++; $error("read done and error both high"); end

endmodule

bind spd_reader spd_reader_asserts asserts0 (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_wb_req     (o_wb),
    .i_wb_rsp     (i_wb),
    .i_char_valid (o_char_valid),
    .i_char       (o_char),
    .i_char_ready (i_char_ready),
    .i_read_done  (o_read_done),
    .i_spd_error  (o_spd_error)
);

//--- tb/tb_top.sv
`timescale 1ns/1ps

module tb_top import spd_pkg::*; ();

    localparam int          TIMEOUT_CYCLES = 20000;
    localparam logic [31:0] SEED           = 32'h9257_4a90;

    logic        clk;
    logic        rst_n;
    logic        reset_req = 1'b0;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        char_valid;
    char_t       char_out;
    logic        char_ready = 1'b0;
    logic        addr_found;
    logic        read_done;
    logic        spd_error;
    logic [31:0] rnd = SEED;
    logic        stall_mode = 1'b0;
    dev_addr_t   dev_addr = 7'h50;
    logic        present = 1'b1;
    logic        err_en = 1'b0;
    spd_index_t  err_idx = '0;
    spd_byte_t   image [0:18];
    logic        timed_out = 1'b0;

    tb_clkgen clk0 (.i_reset_req(reset_req), .o_clk(clk), .o_rst_n(rst_n));

    spd_reader dut0 (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .o_wb         (wb_req),
        .i_wb         (wb_rsp),
        .o_char_valid (char_valid),
        .o_char       (char_out),
        .i_char_ready (char_ready),
        .o_addr_found (addr_found),
        .o_read_done  (read_done),
        .o_spd_error  (spd_error)
    );

    tb_spd_model model0 (
        .i_clk (clk), .i_rst_n (rst_n), .i_wb (wb_req), .o_wb (wb_rsp), .i_rand (rnd),
        .i_dev_addr (dev_addr), .i_present (present), .i_err_en (err_en),
        .i_err_idx (err_idx), .i_image (image)
    );

    tb_checker chk0 (
        .i_clk (clk), .i_rst_n (rst_n), .i_char_valid (char_valid), .i_char (char_out),
        .i_char_ready (char_ready), .i_addr_found (addr_found), .i_read_done (read_done),
        .i_spd_error (spd_error), .i_image (image)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    always @(posedge clk) begin
        rnd        <= xorshift32(rnd);
        char_ready <= stall_mode ? (rnd[1:0] == 2'b00) : 1'b1;   // mostly low when stalling
    end

    task automatic load_image(input spd_byte_t dram_type, input spd_byte_t module_type,
                              input spd_byte_t bus_width);
        @(posedge clk);
        for (int i = 0; i <= 18; i++) begin
            image[i] <= 8'(i * 37 + 5);
        end
        image[1]  <= 8'h13;
        image[2]  <= dram_type;
        image[3]  <= module_type;
        image[8]  <= bus_width;
        image[18] <= 8'h69;
    endtask

    task automatic finish_run();
        int unsigned total;
        total = chk0.error_total() + dut0.asserts0.fail_count;
        chk0.report_counts(dut0.asserts0.fail_count);
        if (total == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        $display("ERROR: timeout while waiting for %s", what);
        chk0.count_failure();
        timed_out = 1'b1;
    endtask

    task automatic run_test(input string name, input dev_addr_t dev, input logic dev_present,
                            input logic nack_en, input spd_index_t nack_idx, input logic stall,
                            input logic exp_found, input logic exp_done, input logic exp_err);
        int n;
        if (timed_out) begin
            return;     // an earlier run never finished
        end
        @(posedge clk);
        reset_req  <= 1'b1;
        dev_addr   <= dev;
        present    <= dev_present;
        err_en     <= nack_en;
        err_idx    <= nack_idx;
        stall_mode <= stall;
        @(posedge clk);
        reset_req <= 1'b0;
        n = 0;
        while (rst_n && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (rst_n) begin
            give_up("reset to assert");
            return;
        end
        chk0.begin_test(name, dev, dev_present, nack_en, nack_idx);
        n = 0;
        while (!rst_n && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (!rst_n) begin
            give_up("reset to release");
            return;
        end
        n = 0;
        while (!read_done && !spd_error && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (!read_done && !spd_error) begin
            give_up("end of report");
            return;
        end
        repeat (2) @(posedge clk);
        chk0.end_test(exp_found, exp_done, exp_err);
    endtask

    initial begin
        for (int i = 0; i <= 18; i++) begin
            image[i] = '0;
        end
        load_image(8'h0B, 8'h03, 8'h03);
        run_test("probe_full_report", 7'h50, 1'b1, 1'b0, 8'd0, 1'b0, 1'b1, 1'b1, 1'b0);
        load_image(8'h0C, 8'h07, 8'h05);
        run_test("alternate_values", 7'h50, 1'b1, 1'b0, 8'd0, 1'b0, 1'b1, 1'b1, 1'b0);
        load_image(8'h0B, 8'h03, 8'h03);
        run_test("back_pressure", 7'h50, 1'b1, 1'b0, 8'd0, 1'b1, 1'b1, 1'b1, 1'b0);
        run_test("mid_read_nack", 7'h50, 1'b1, 1'b1, 8'd3, 1'b0, 1'b1, 1'b0, 1'b1);
        run_test("no_device", 7'h50, 1'b0, 1'b0, 8'd0, 1'b0, 1'b0, 1'b0, 1'b1);
        finish_run();
    end

endmodule

//--- spd_reader.f
design/spd_pkg.sv
design/spd_sequencer.sv
design/spd_line_formatter.sv
design/spd_text_sender.sv
design/spd_reader.sv
tb/tb_clkgen.sv
tb/tb_spd_model.sv
tb/tb_checker.sv
tb/spd_reader_asserts.sv
tb/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_top
FILELIST  ?= spd_reader.f
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
